// ==== design/ebox_macros.svh ====
`ifndef EBOX_MACROS_SVH
`define EBOX_MACROS_SVH

// Widths
`define CRAM_WIDTH 32
`define WORD_WIDTH 36
`define HALF_WIDTH 18

// Microword fields, msb:lsb
`define CRAM_AR    31:29
`define CRAM_ARX   28:26
`define CRAM_MQ    25
`define CRAM_DISP  24:20
`define CRAM_SPEC  19:15
`define CRAM_COND  14:9
`define CRAM_MAGIC 8:0

`define DISP_NONE   5'd0
`define DISP_RETURN 5'd1
`define DISP_NICOND 5'd2
`define DISP_MUL    5'd3
`define DISP_DIV    5'd4
`define DISP_NORM   5'd5

`define SPEC_NONE      5'd0
`define SPEC_LOAD_PC   5'd1
`define SPEC_GEN_CRY18 5'd2
`define SPEC_MQ_SHIFT  5'd3
`define SPEC_AD_LONG   5'd4
`define SPEC_ARL_IND   5'd5

// Zero is no condition
`define COND_ARLL_LOAD 6'o01
`define COND_ARLR_LOAD 6'o02
`define COND_AR_CLR    6'o04
`define COND_ARX_CLR   6'o05
`define COND_REG_CTL   6'o07
`define COND_DIAG_FUNC 6'o34

`define DIAG_LD_076 7'o076
`define DIAG_LD_071 7'o071
`define DIAG_RD_10X 7'o100

`endif

// ==== design/eboxPkg.sv ====
package eboxPkg;

  // Magic field, either register controls or a diagnostic function
  typedef union packed {
    struct packed {
      logic       ldArl;
      logic       ldArr;
      logic       clrMq;
      logic       clrArx;
      logic       clrArl;
      logic       clrArr;
      logic [1:0] arlSel;
      logic       mqClr2;
    } regCtl;
    struct packed {
      logic [1:0] spare;
      logic [6:0] func;
    } diagFunc;
  } magicWord;

endpackage

// ==== design/ctlDecode.sv ====
`timescale 1ns/1ps
`include "ebox_macros.svh"

module ctlDecode (
  input  logic                   CTL,
  input  logic                   rstN,
  input  logic [`CRAM_WIDTH-1:0] cramWord,
  input  logic                   cramValid,
  output logic [1:0]             arlSel,
  output logic [1:0]             arrSel,
  output logic                   arlClr,
  output logic                   arrClr,
  output logic                   arxLoad,
  output logic                   arxClr,
  output logic [1:0]             mqSel,
  output logic                   adLong,
  output logic                   loadPc,
  output logic                   dispRet,
  output logic                   genCry18,
  output logic                   diagFuncValid,
  output eboxPkg::magicWord      diagFunc
);

  import eboxPkg::*;

  logic [`CRAM_WIDTH-1:0] cram;
  logic [2:0] arFld;
  logic [2:0] arxFld;
  logic       mqFld;
  logic [4:0] disp;
  logic [4:0] spec;
  logic [5:0] cond;
  magicWord   magic;
  logic       dispMul;
  logic       dispDiv;
  logic       specMqShift;
  logic       specArlInd;
  logic       condArll;
  logic       condArlr;
  logic       condArClr;
  logic       condArxClr;
  logic       regCtl;
  logic       useMagic;
  logic       mqClear;
  logic [1:0] fieldArl;

  // Empty word when nothing is strobed in
  always_ff @(posedge CTL or negedge rstN) begin
    if (!rstN) begin
      cram <= '0;
    end else if (cramValid) begin
      cram <= cramWord;
    end else begin
      cram <= '0;
    end
  end

  assign arFld  = cram[`CRAM_AR];
  assign arxFld = cram[`CRAM_ARX];
  assign mqFld  = cram[`CRAM_MQ];
  assign disp   = cram[`CRAM_DISP];
  assign spec   = cram[`CRAM_SPEC];
  assign cond   = cram[`CRAM_COND];
  assign magic  = cram[`CRAM_MAGIC];

  assign dispMul     = disp == `DISP_MUL;
  assign dispDiv     = disp == `DISP_DIV;
  assign specMqShift = spec == `SPEC_MQ_SHIFT;
  assign specArlInd  = spec == `SPEC_ARL_IND;
  assign condArll    = cond == `COND_ARLL_LOAD;
  assign condArlr    = cond == `COND_ARLR_LOAD;
  assign condArClr   = cond == `COND_AR_CLR;
  assign condArxClr  = cond == `COND_ARX_CLR;
  assign regCtl      = cond == `COND_REG_CTL;
  assign useMagic    = regCtl | specArlInd;

  // Misc strobes
  assign adLong   = dispMul | dispDiv | (disp == `DISP_NORM) |
                    (spec == `SPEC_AD_LONG) | specMqShift;
  assign loadPc   = (spec == `SPEC_LOAD_PC) | (disp == `DISP_NICOND);
  assign dispRet  = disp == `DISP_RETURN;
  assign genCry18 = spec == `SPEC_GEN_CRY18;

  // Clears come first
  assign arlClr  = condArClr | (useMagic & magic.regCtl.clrArl);
  assign arrClr  = condArClr | (useMagic & magic.regCtl.clrArr);
  assign arxClr  = condArxClr | (useMagic & magic.regCtl.clrArx);
  assign mqClear = (useMagic & magic.regCtl.clrMq) | (regCtl & magic.regCtl.mqClr2);
  assign arxLoad = (arxFld != 3'b000) & ~arxClr;

  // ARL_IND takes the left select from the magic field
  assign fieldArl = specArlInd ? magic.regCtl.arlSel : arFld[1:0];

  always_comb begin
    if (arlClr) begin
      arlSel = 2'd0;
    end else if (condArll | (regCtl & magic.regCtl.ldArl)) begin
      arlSel = 2'd1;
    end else if (condArlr) begin
      arlSel = 2'd0;
    end else begin
      arlSel = fieldArl;
    end
  end

  // AR field bit 2 keeps the right half
  always_comb begin
    if (arrClr) begin
      arrSel = 2'd0;
    end else if (condArlr | (regCtl & magic.regCtl.ldArr)) begin
      arrSel = 2'd1;
    end else if (condArll | arFld[2]) begin
      arrSel = 2'd0;
    end else begin
      arrSel = arFld[1:0];
    end
  end

  always_comb begin
    if (mqClear) begin
      mqSel = 2'd3;
    end else if (dispMul | dispDiv | specMqShift) begin
      mqSel = 2'd2;
    end else if (mqFld) begin
      mqSel = 2'd1;
    end else begin
      mqSel = 2'd0;
    end
  end

  // Microcode side of a diagnostic function
  assign diagFuncValid = cond == `COND_DIAG_FUNC;

  always_comb begin
    diagFunc = '0;
    if (diagFuncValid) begin
      diagFunc.diagFunc.func = magic.diagFunc.func;
    end
  end

endmodule

// ==== design/arDatapath.sv ====
`timescale 1ns/1ps
`include "ebox_macros.svh"

module arDatapath (
  input  logic                   CTL,
  input  logic                   rstN,
  input  logic [`WORD_WIDTH-1:0] adResult,
  input  logic [`WORD_WIDTH-1:0] memData,
  input  logic [`WORD_WIDTH-1:0] diagData,
  input  logic [1:0]             arlSel,
  input  logic [1:0]             arrSel,
  input  logic                   arlClr,
  input  logic                   arrClr,
  input  logic                   arxLoad,
  input  logic                   arxClr,
  input  logic [1:0]             mqSel,
  output logic [`WORD_WIDTH-1:0] ar,
  output logic [`WORD_WIDTH-1:0] arx,
  output logic [`WORD_WIDTH-1:0] mq
);

  logic [`HALF_WIDTH-1:0] arlNext;
  logic [`HALF_WIDTH-1:0] arrNext;

  function automatic logic [`HALF_WIDTH-1:0] pickHalf(
    input logic [1:0]             sel,
    input logic [`HALF_WIDTH-1:0] hold,
    input logic [`HALF_WIDTH-1:0] ad,
    input logic [`HALF_WIDTH-1:0] mem,
    input logic [`HALF_WIDTH-1:0] diag
  );
    case (sel)
      2'd1:    pickHalf = ad;
      2'd2:    pickHalf = mem;
      2'd3:    pickHalf = diag;
      default: pickHalf = hold;
    endcase
  endfunction

  // Each half picks its own source
  assign arlNext = arlClr ? '0 :
    pickHalf(arlSel, ar[`WORD_WIDTH-1:`HALF_WIDTH], adResult[`WORD_WIDTH-1:`HALF_WIDTH],
             memData[`WORD_WIDTH-1:`HALF_WIDTH], diagData[`WORD_WIDTH-1:`HALF_WIDTH]);
  assign arrNext = arrClr ? '0 :
    pickHalf(arrSel, ar[`HALF_WIDTH-1:0], adResult[`HALF_WIDTH-1:0],
             memData[`HALF_WIDTH-1:0], diagData[`HALF_WIDTH-1:0]);

  always_ff @(posedge CTL or negedge rstN) begin
    if (!rstN) begin
      ar  <= '0;
      arx <= '0;
      mq  <= '0;
    end else begin
      ar <= {arlNext, arrNext};
      if (arxClr) begin
        arx <= '0;
      end else if (arxLoad) begin
        arx <= adResult;
      end
      case (mqSel)
        2'd1:    mq <= adResult;
        2'd2:    mq <= {mq[`WORD_WIDTH-2:0], ar[0]};
        2'd3:    mq <= '0;
        default: mq <= mq;
      endcase
    end
  end

  // Decode must resolve ARX load against clear
  arxLoadClr: assert property (@(posedge CTL) disable iff (!rstN)
    !(arxLoad && arxClr));

endmodule

// ==== design/diagPort.sv ====
`timescale 1ns/1ps
`include "ebox_macros.svh"

module diagPort (
  input  logic                   CTL,
  input  logic                   rstN,
  input  logic                   cyc,
  input  logic                   stb,
  input  logic                   we,
  input  logic [6:0]             adr,
  input  logic [`WORD_WIDTH-1:0] datWr,
  output logic [`WORD_WIDTH-1:0] datRd,
  output logic                   ack,
  input  logic                   diagFuncValid,
  input  eboxPkg::magicWord      diagFunc,
  input  logic [`WORD_WIDTH-1:0] adResult,
  input  logic [`WORD_WIDTH-1:0] ar,
  input  logic [`WORD_WIDTH-1:0] mq,
  input  logic                   adLong,
  input  logic                   loadPc,
  output logic [`WORD_WIDTH-1:0] diagData
);

  localparam logic [6:0] rdGroup = `DIAG_RD_10X;

  logic req;
  logic served;
  logic start;
  logic ucLd071;
  logic memReset;
  logic chanClkStop;
  logic ldEbusReg;
  logic forceExtend;
  logic diag4;
  logic [`WORD_WIDTH-1:0] status;

  assign req     = cyc & stb;
  assign start   = req & ~served;
  assign ucLd071 = diagFuncValid & (diagFunc.diagFunc.func == `DIAG_LD_071);

  // One ack per strobe, rearmed once stb drops
  always_ff @(posedge CTL or negedge rstN) begin
    if (!rstN) begin
      ack    <= 1'b0;
      served <= 1'b0;
    end else begin
      ack <= start;
      if (!req) begin
        served <= 1'b0;
      end else if (start) begin
        served <= 1'b1;
      end
    end
  end

  always_ff @(posedge CTL or negedge rstN) begin
    if (!rstN) begin
      {diag4, forceExtend, ldEbusReg, chanClkStop, memReset} <= '0;
      diagData <= '0;
    end else begin
      if (start && we && adr == `DIAG_LD_076) begin
        {diag4, forceExtend, ldEbusReg, chanClkStop, memReset} <= datWr[4:0];
      end
      // Microcode load takes adResult
      if (ucLd071) begin
        diagData <= adResult;
      end else if (start && we && adr == `DIAG_LD_071) begin
        diagData <= datWr;
      end
    end
  end

  // Status words of the 10x read group
  always_comb begin
    status = '0;
    if (adr[6:3] == rdGroup[6:3]) begin
      case (adr[2:0])
        3'd0:    status[4:0] = {diag4, forceExtend, ldEbusReg, chanClkStop, memReset};
        3'd1:    status[1:0] = {loadPc, adLong};
        3'd2:    status = ar;
        3'd3:    status = mq;
        default: status = '0;
      endcase
    end
  end

  always_ff @(posedge CTL) begin
    if (start) begin
      datRd <= we ? '0 : status;
    end
  end

  ackOneCycle: assert property (@(posedge CTL) disable iff (!rstN) ack |=> !ack);

endmodule

// ==== design/eboxCtl.sv ====
`timescale 1ns/1ps
`include "ebox_macros.svh"

module eboxCtl (
  input  logic                   CTL,
  input  logic                   rstN,
  input  logic [`CRAM_WIDTH-1:0] cramWord,
  input  logic                   cramValid,
  input  logic [`WORD_WIDTH-1:0] adResult,
  input  logic [`WORD_WIDTH-1:0] memData,
  input  logic                   cyc,
  input  logic                   stb,
  input  logic                   we,
  input  logic [6:0]             adr,
  input  logic [`WORD_WIDTH-1:0] datWr,
  output logic [`WORD_WIDTH-1:0] datRd,
  output logic                   ack,
  output logic [`WORD_WIDTH-1:0] ar,
  output logic [`WORD_WIDTH-1:0] arx,
  output logic [`WORD_WIDTH-1:0] mq,
  output logic                   adLong,
  output logic                   loadPc,
  output logic                   dispRet,
  output logic                   genCry18
);

  import eboxPkg::*;

  logic [1:0] arlSel;
  logic [1:0] arrSel;
  logic       arlClr;
  logic       arrClr;
  logic       arxLoad;
  logic       arxClr;
  logic [1:0] mqSel;
  logic       diagFuncValid;
  magicWord   diagFunc;
  logic [`WORD_WIDTH-1:0] diagData;

  ctlDecode ctlDecode_inst (
    .CTL(CTL), .rstN(rstN), .cramWord(cramWord), .cramValid(cramValid),
    .arlSel(arlSel), .arrSel(arrSel), .arlClr(arlClr), .arrClr(arrClr),
    .arxLoad(arxLoad), .arxClr(arxClr), .mqSel(mqSel),
    .adLong(adLong), .loadPc(loadPc), .dispRet(dispRet), .genCry18(genCry18),
    .diagFuncValid(diagFuncValid), .diagFunc(diagFunc)
  );

  arDatapath arDatapath_inst (
    .CTL(CTL), .rstN(rstN), .adResult(adResult), .memData(memData),
    .diagData(diagData), .arlSel(arlSel), .arrSel(arrSel),
    .arlClr(arlClr), .arrClr(arrClr), .arxLoad(arxLoad), .arxClr(arxClr),
    .mqSel(mqSel), .ar(ar), .arx(arx), .mq(mq)
  );

  diagPort diagPort_inst (
    .CTL(CTL), .rstN(rstN), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
    .datWr(datWr), .datRd(datRd), .ack(ack),
    .diagFuncValid(diagFuncValid), .diagFunc(diagFunc), .adResult(adResult),
    .ar(ar), .mq(mq), .adLong(adLong), .loadPc(loadPc), .diagData(diagData)
  );

endmodule

// ==== test/eboxCtlTb.sv ====
`timescale 1ns/1ps
`include "ebox_macros.svh"

module eboxCtlTb;

  import eboxPkg::*;

  localparam int NUM_VEC   = 27;
  localparam int VEC_WORDS = 8;

  logic                   CTL;
  logic                   rstN;
  logic [`CRAM_WIDTH-1:0] cramWord;
  logic                   cramValid;
  logic [`WORD_WIDTH-1:0] adResult;
  logic [`WORD_WIDTH-1:0] memData;
  logic                   cyc;
  logic                   stb;
  logic                   we;
  logic [6:0]             adr;
  logic [`WORD_WIDTH-1:0] datWr;
  logic [`WORD_WIDTH-1:0] datRd;
  logic                   ack;
  logic [`WORD_WIDTH-1:0] ar;
  logic [`WORD_WIDTH-1:0] arx;
  logic [`WORD_WIDTH-1:0] mq;
  logic                   adLong;
  logic                   loadPc;
  logic                   dispRet;
  logic                   genCry18;

  logic [`WORD_WIDTH-1:0] vecMem [0:NUM_VEC*VEC_WORDS-1];
  logic [31:0]            lfsr;
  int                     errors;
  int                     failedTests;

  eboxCtl eboxCtl_inst (.*);

  initial begin
    CTL = 1'b0;
    forever #50 CTL = ~CTL;
  end

  // Sized from the vector count plus reset
  initial begin
    repeat (NUM_VEC * 10 + 20) @(posedge CTL);
    $display("Timeout: run did not finish within %0d clock periods", NUM_VEC * 10 + 20);
    $display("FAIL: see errors above");
    $finish;
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    lfsrStep = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic drawRandom(output logic [`WORD_WIDTH-1:0] v);
    for (int i = 0; i < `WORD_WIDTH; i++) begin
      lfsr = lfsrStep(lfsr);
      v[i] = lfsr[0];
    end
  endtask

  function automatic string describeMicro(input logic [`CRAM_WIDTH-1:0] w);
    magicWord magic;
    magic = w[`CRAM_MAGIC];
    if (w[`CRAM_COND] == `COND_DIAG_FUNC) begin
      return $sformatf("microword %h, diag function %o", w, magic.diagFunc.func);
    end
    if (w[`CRAM_COND] == `COND_REG_CTL) begin
      return $sformatf("microword %h, reg ctl clrMq %b", w, magic.regCtl.clrMq);
    end
    return $sformatf("microword %h", w);
  endfunction

  task automatic compareWord(input string name, input logic [`WORD_WIDTH-1:0] got,
                             input logic [`WORD_WIDTH-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic compareBit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic checkResult(input int chk, input logic [`WORD_WIDTH-1:0] exp);
    case (chk)
      1:       compareWord("ar", ar, exp);
      2:       compareWord("arx", arx, exp);
      3:       compareWord("mq", mq, exp);
      4:       compareWord("datRd", datRd, exp);
      5:       compareBit("adLong", adLong, exp[0]);
      6:       compareBit("loadPc", loadPc, exp[0]);
      default: ;
    endcase
  endtask

  // Strobes one edge after acceptance, registers one edge later
  task automatic runMicro(input logic [`CRAM_WIDTH-1:0] w, input logic [`WORD_WIDTH-1:0] ad,
                          input logic [`WORD_WIDTH-1:0] mem, input int chk,
                          input logic [`WORD_WIDTH-1:0] exp);
    @(negedge CTL);
    cramWord  = w;
    cramValid = 1'b1;
    adResult  = ad;
    memData   = mem;
    @(negedge CTL);
    cramValid = 1'b0;
    compareBit("dispRet", dispRet, w[`CRAM_DISP] == `DISP_RETURN);
    compareBit("genCry18", genCry18, w[`CRAM_SPEC] == `SPEC_GEN_CRY18);
    if (chk >= 5) begin
      checkResult(chk, exp);
    end
    @(negedge CTL);
    if (chk >= 1 && chk <= 3) begin
      checkResult(chk, exp);
    end
  endtask

  task automatic runWishbone(input logic write, input logic [6:0] a,
                             input logic [`WORD_WIDTH-1:0] data, input int chk,
                             input logic [`WORD_WIDTH-1:0] exp);
    int waitCycles;
    int extraAcks;
    waitCycles = 0;
    extraAcks  = 0;
    @(negedge CTL);
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = write;
    adr   = a;
    datWr = data;
    @(negedge CTL);
    while (!ack && waitCycles < 8) begin
      @(negedge CTL);
      waitCycles++;
    end
    if (!ack) begin
      $display("No ack for the transaction at address %o", a);
      errors++;
    end else if (chk == 4) begin
      checkResult(chk, exp);
    end
    // Strobe still held, so no further ack may arrive
    repeat (2) begin
      @(negedge CTL);
      if (ack) begin
        extraAcks++;
      end
    end
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
    if (extraAcks != 0) begin
      $display("Second ack while stb was held at address %o", a);
      errors++;
    end
  endtask

  task automatic finishTest(input int num, input string tag, input int errBefore);
    if (errors == errBefore) begin
      $display("Test %0d (%s) passed", num, tag);
    end else begin
      $display("Test %0d (%s) failed", num, tag);
      failedTests++;
    end
  endtask

  initial begin
    int base;
    int kind;
    int flags;
    int chk;
    int errBefore;
    logic [`WORD_WIDTH-1:0] ad;
    logic [`WORD_WIDTH-1:0] mem;
    logic [`WORD_WIDTH-1:0] src;
    logic [`WORD_WIDTH-1:0] mask;
    logic [`WORD_WIDTH-1:0] expVal;
    lfsr        = 32'haee7352f;
    errors      = 0;
    failedTests = 0;
    rstN        = 1'b0;
    cramWord    = '0;
    cramValid   = 1'b0;
    adResult    = '0;
    memData     = '0;
    cyc         = 1'b0;
    stb         = 1'b0;
    we          = 1'b0;
    adr         = '0;
    datWr       = '0;
    $readmemh("test/ctlVectors.mem", vecMem);
    repeat (4) @(posedge CTL);
    @(negedge CTL);
    rstN = 1'b1;
    errBefore = errors;
    compareWord("ar", ar, '0);
    compareWord("arx", arx, '0);
    compareWord("mq", mq, '0);
    compareBit("ack", ack, 1'b0);
    compareBit("loadPc", loadPc, 1'b0);
    compareBit("adLong", adLong, 1'b0);
    compareBit("dispRet", dispRet, 1'b0);
    compareBit("genCry18", genCry18, 1'b0);
    finishTest(0, "reset state", errBefore);

    for (int n = 0; n < NUM_VEC; n++) begin
      base      = n * VEC_WORDS;
      errBefore = errors;
      kind      = int'(vecMem[base]);
      flags     = int'(vecMem[base+4]);
      chk       = int'(vecMem[base+5]);
      mask      = vecMem[base+7];
      ad        = (kind != 0 || (flags & 4) != 0) ? adResult : vecMem[base+2];
      mem       = vecMem[base+3];
      if ((flags & 1) != 0) begin
        drawRandom(ad);
      end
      if ((flags & 2) != 0) begin
        drawRandom(mem);
      end
      // Masked bits of the expected value come from the driven operand
      src    = ((flags & 2) != 0) ? mem : ad;
      expVal = (vecMem[base+6] & ~mask) | (src & mask);
      case (kind)
        0: begin
          runMicro(vecMem[base+1][`CRAM_WIDTH-1:0], ad, mem, chk, expVal);
          finishTest(n + 1, describeMicro(vecMem[base+1][`CRAM_WIDTH-1:0]), errBefore);
        end
        1: begin
          runWishbone(1'b1, vecMem[base+1][6:0], mem, chk, expVal);
          finishTest(n + 1, $sformatf("write %o", vecMem[base+1][6:0]), errBefore);
        end
        2: begin
          runWishbone(1'b0, vecMem[base+1][6:0], mem, chk, expVal);
          finishTest(n + 1, $sformatf("read %o", vecMem[base+1][6:0]), errBefore);
        end
        default: begin
          $display("Vector %0d has an unknown operation kind %0d", n, kind);
          errors++;
          finishTest(n + 1, "bad vector", errBefore);
        end
      endcase
    end

    $display("%0d tests, %0d failed, %0d errors", NUM_VEC + 1, failedTests, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== test/ctlVectors.mem ====
// kind (0 micro, 1 wb write, 2 wb read), word (cram or adr), adResult, memData or datWr
// flags (1 random ad, 2 random mem, 4 hold ad), check (1 ar, 2 arx, 3 mq, 4 datRd, 5 adLong, 6 loadPc), expected, mask
0 20000000 000000000 000000000 1 1 000000000 FFFFFFFFF
0 40000000 000000000 000000000 2 1 000000000 FFFFFFFFF
0 40000000 000000000 123456789 0 1 123456789 000000000
0 00000200 000000000 000000000 1 1 123456789 FFFFC0000
0 20000800 111111111 000000000 0 1 000000000 000000000
0 00000400 000000000 000000000 1 1 000000000 00003FFFF
0 40000000 000000000 000000001 0 1 000000001 000000000
0 02000000 0F0F0F0F0 000000000 0 3 0F0F0F0F0 000000000
0 00300000 000000000 000000000 0 3 1E1E1E1E1 000000000
0 00300000 000000000 000000000 0 5 000000001 000000000
0 00500000 000000000 000000000 0 5 000000001 000000000
0 00020000 000000000 000000000 0 5 000000001 000000000
0 00000000 000000000 000000000 0 5 000000000 000000000
0 00008000 000000000 000000000 0 6 000000001 000000000
0 22000E40 000000005 000000000 0 3 000000000 000000000
0 40000E18 000000000 555555555 0 1 000000000 000000000
0 20028004 000000000 777777777 1 1 777740000 00003FFFF
0 04000000 000000000 000000000 1 2 000000000 FFFFFFFFF
0 04000A00 000000000 000000000 0 2 000000000 000000000
1 3E 000000000 000000015 0 0 000000000 000000000
2 40 000000000 000000000 0 4 000000015 000000000
2 10 000000000 000000000 0 4 000000000 000000000
1 39 000000000 9ABCDEF01 0 0 000000000 000000000
0 60000000 000000000 000000000 0 1 9ABCDEF01 000000000
0 00003839 000000000 000000000 1 0 000000000 000000000
0 60000000 000000000 000000000 4 1 000000000 FFFFFFFFF
2 42 000000000 000000000 0 4 000000000 FFFFFFFFF

// ==== list.f ====
+incdir+design
design/eboxPkg.sv
design/ctlDecode.sv
design/arDatapath.sv
design/diagPort.sv
design/eboxCtl.sv
test/eboxCtlTb.sv

// ==== Makefile ====
TOP = eboxCtlTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log
